// ==== design/tmip_data_pkg.sv ====
// data types for the matcher; pixels are signed 16 bit, images at most 16x16 (256 words)
`default_nettype none

package tmip_data_pkg;

	localparam int TAPS          = 9;
	localparam int BRIGHT_OFFSET = 50;

	typedef logic signed [15:0] pixel_t;  // image pixel or template coefficient
	typedef logic signed [39:0] corr_t;   // correlation sum
	typedef logic [7:0]         addr_t;   // address into either memory
	typedef logic [3:0]         coord_t;  // row or column
	typedef logic [4:0]         side_t;   // 4, 8 or 16

	// flips and zoom-in are not supported, so only three codes
	typedef enum logic [2:0] {
		ACT_XCORR  = 3'd0,
		ACT_POOL   = 3'd1,
		ACT_ADJUST = 3'd7
	} action_t;

	typedef pixel_t template_t [TAPS];

endpackage

`default_nettype wire

// ==== design/tmip_ctrl_pkg.sv ====
// control types for the action sequencer; one engine owns the image port at a time
`default_nettype none

package tmip_ctrl_pkg;

	typedef enum logic [2:0] {
		LOAD,
		DISPATCH,
		POOL,
		ADJUST,
		XCORR,
		STREAM
	} seq_state_t;

	// owner of the image memory port
	typedef enum logic [1:0] {
		SEL_LOAD,
		SEL_POOL,
		SEL_ADJUST,
		SEL_XCORR
	} engine_sel_t;

endpackage

`default_nettype wire

// ==== design/mem_if.sv ====
// one synchronous memory port; rdata returns the word addressed in the previous cycle
`default_nettype none

interface mem_if
	import tmip_data_pkg::*;
#(
	parameter type data_t = pixel_t
);
	addr_t addr;
	logic  wen;
	data_t wdata;
	data_t rdata;

	modport engine (output addr, output wen, output wdata, input rdata);
	modport memory (input addr, input wen, input wdata, output rdata);

endinterface

`default_nettype wire

// ==== design/sync_ram.sv ====
// behavioural single-port RAM, one-cycle read latency, read during write returns old data
`default_nettype none

module sync_ram
	import tmip_data_pkg::*;
#(
	parameter int  IMG_DEPTH = 256,
	parameter type data_t    = pixel_t
) (
	input wire    clk,
	mem_if.memory port
);

	data_t mem [IMG_DEPTH];

	always_ff @(posedge clk) begin
		if (port.wen)
			mem[port.addr] <= port.wdata;
		port.rdata <= mem[port.addr];  // registered read every cycle
	end

endmodule

`default_nettype wire

// ==== design/input_loader.sv ====
// load path; expects img_size on the first beat and at most MAX_ACTIONS actions per run
`default_nettype none

module input_loader
	import tmip_data_pkg::*;
#(
	parameter int MAX_ACTIONS = 8
) (
	input  wire     clk,
	input  wire     rst_n,
	input  wire     in_valid,
	input  wire     in_valid_2,
	input  pixel_t  image,
	input  pixel_t  template,
	input  side_t   img_size,
	input  action_t action,
	mem_if.engine   mem,
	output side_t   side_in,
	output template_t taps,
	output action_t actions [MAX_ACTIONS],
	output logic    loaded
);

	localparam int AW = $clog2(MAX_ACTIONS);

	addr_t         cnt;      // pixel beat
	logic [AW-1:0] act_cnt;
	logic          in_valid_2_d;

	// pixels go straight to memory on their beat
	assign mem.addr  = cnt;
	assign mem.wen   = in_valid;
	assign mem.wdata = image;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt     <= '0;
			side_in <= '0;
		end else if (in_valid) begin
			cnt <= cnt + 8'd1;
			if (cnt == 8'd0)
				side_in <= img_size;
		end else begin
			cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && cnt < TAPS)
			taps[cnt[3:0]] <= template;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			act_cnt      <= '0;
			in_valid_2_d <= 1'b0;
			loaded       <= 1'b0;
			for (int i = 0; i < MAX_ACTIONS; i++)
				actions[i] <= ACT_XCORR;
		end else begin
			in_valid_2_d <= in_valid_2;
			loaded       <= in_valid_2_d && !in_valid_2;  // queue complete
			if (in_valid_2) begin
				actions[act_cnt] <= action;
				act_cnt          <= act_cnt + 1'b1;
			end else begin
				act_cnt <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/op_sequencer.sv ====
// plays back the action queue; relies on the queue ending with ACT_XCORR
`default_nettype none

module op_sequencer
	import tmip_data_pkg::*;
	import tmip_ctrl_pkg::*;
#(
	parameter int MAX_ACTIONS = 8
) (
	input  wire     clk,
	input  wire     rst_n,
	input  wire     loaded,
	input  side_t   side_in,
	input  action_t actions [MAX_ACTIONS],
	input  wire     pool_done,
	input  wire     adjust_done,
	input  wire     xcorr_done,
	input  wire     stream_done,
	output side_t   side,
	output logic    pool_start,
	output logic    adjust_start,
	output logic    xcorr_start,
	output logic    stream_start,
	mem_if.memory   loader_mem,
	mem_if.memory   pool_mem,
	mem_if.memory   adjust_mem,
	mem_if.memory   xcorr_mem,
	mem_if.engine   img_mem
);

	localparam int AW = $clog2(MAX_ACTIONS);

	seq_state_t    state;
	engine_sel_t   sel;
	logic [AW-1:0] ptr;

	//============================================================
	// state machine
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= LOAD;
			side         <= '0;
			ptr          <= '0;
			pool_start   <= 1'b0;
			adjust_start <= 1'b0;
			xcorr_start  <= 1'b0;
			stream_start <= 1'b0;
		end else begin
			pool_start   <= 1'b0;
			adjust_start <= 1'b0;
			xcorr_start  <= 1'b0;
			stream_start <= 1'b0;
			case (state)
				LOAD: if (loaded) begin
					state <= DISPATCH;
					side  <= side_in;
					ptr   <= '0;
				end
				DISPATCH: begin
					ptr <= ptr + 1'b1;
					case (actions[ptr])
						ACT_POOL: begin
							state      <= POOL;
							pool_start <= 1'b1;
						end
						ACT_ADJUST: begin
							state        <= ADJUST;
							adjust_start <= 1'b1;
						end
						default: begin
							state       <= XCORR;
							xcorr_start <= 1'b1;
						end
					endcase
				end
				POOL, ADJUST: if (pool_done || adjust_done) begin
					state <= DISPATCH;
					if (side > 5'd4)
						side <= side >> 1;  // both rewrites halve down to 4
				end
				XCORR: if (xcorr_done) begin
					state        <= STREAM;
					stream_start <= 1'b1;
				end
				STREAM: if (stream_done)
					state <= LOAD;
				default: state <= LOAD;
			endcase
		end
	end

	//============================================================
	// image port mux
	//============================================================
	always_comb begin
		case (state)
			POOL:    sel = SEL_POOL;
			ADJUST:  sel = SEL_ADJUST;
			XCORR:   sel = SEL_XCORR;
			default: sel = SEL_LOAD;
		endcase
	end

	always_comb begin
		case (sel)
			SEL_POOL: begin
				img_mem.addr = pool_mem.addr; img_mem.wen = pool_mem.wen;
				img_mem.wdata = pool_mem.wdata;
			end
			SEL_ADJUST: begin
				img_mem.addr = adjust_mem.addr; img_mem.wen = adjust_mem.wen;
				img_mem.wdata = adjust_mem.wdata;
			end
			SEL_XCORR: begin
				img_mem.addr = xcorr_mem.addr; img_mem.wen = xcorr_mem.wen;
				img_mem.wdata = xcorr_mem.wdata;
			end
			default: begin
				img_mem.addr = loader_mem.addr; img_mem.wen = loader_mem.wen;
				img_mem.wdata = loader_mem.wdata;
			end
		endcase
	end

	// read data is shared
	assign loader_mem.rdata = img_mem.rdata;
	assign pool_mem.rdata   = img_mem.rdata;
	assign adjust_mem.rdata = img_mem.rdata;
	assign xcorr_mem.rdata  = img_mem.rdata;

endmodule

`default_nettype wire

// ==== design/pool_engine.sv ====
// 2x2 max pooling in place, five cycles per output pixel; side 4 is passed through
`default_nettype none

module pool_engine
	import tmip_data_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  wire   start,
	input  side_t side,
	output logic  done,
	mem_if.engine mem
);

	logic   busy;
	logic [2:0] phase;
	coord_t orow, ocol;
	pixel_t mx;
	addr_t  base;
	coord_t last;

	assign last = coord_t'((side >> 1) - 5'd1);
	assign base = addr_t'({orow, 1'b0}) * addr_t'(side) + addr_t'({ocol, 1'b0});

	always_comb begin
		case (phase)
			3'd0:    mem.addr = base;
			3'd1:    mem.addr = base + 8'd1;
			3'd2:    mem.addr = base + addr_t'(side);
			3'd3:    mem.addr = base + addr_t'(side) + 8'd1;
			default: mem.addr = addr_t'(orow) * addr_t'(side >> 1) + addr_t'(ocol);  // packed
		endcase
	end

	assign mem.wen   = busy && phase == 3'd4;
	assign mem.wdata = (mem.rdata > mx) ? mem.rdata : mx;

	always_ff @(posedge clk) begin
		if (phase == 3'd1)
			mx <= mem.rdata;
		else if (phase != 3'd0)
			mx <= mem.wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			phase <= '0;
			orow  <= '0;
			ocol  <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= side != 5'd4;
				done  <= side == 5'd4;
				phase <= '0;
				orow  <= '0;
				ocol  <= '0;
			end else if (busy) begin
				phase <= (phase == 3'd4) ? 3'd0 : phase + 3'd1;
				if (phase == 3'd4) begin
					ocol <= (ocol == last) ? '0 : ocol + 4'd1;
					if (ocol == last)
						orow <= orow + 4'd1;
					if (ocol == last && orow == last) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/adjust_engine.sv ====
// centre crop plus brightness, in place, two cycles per pixel; sum wraps at 16 bits
`default_nettype none

module adjust_engine
	import tmip_data_pkg::*;
(
	input  wire   clk,
	input  wire   rst_n,
	input  wire   start,
	input  side_t side,
	output logic  done,
	mem_if.engine mem
);

	logic   busy, phase;
	coord_t r, c, last, off;
	pixel_t even;

	assign last = coord_t'(((side > 5'd4) ? side >> 1 : side) - 5'd1);
	assign off  = (side > 5'd4) ? coord_t'(side >> 2) : '0;  // side 4 keeps everything
	assign even = {mem.rdata[15:1], 1'b0};

	assign mem.addr = phase ? addr_t'(r) * addr_t'(last + 4'd1) + addr_t'(c)
	                        : addr_t'(r + off) * addr_t'(side) + addr_t'(c + off);
	assign mem.wen   = busy && phase;
	assign mem.wdata = (even >>> 1) + pixel_t'(BRIGHT_OFFSET);  // even, so shift is exact

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			phase <= 1'b0;
			r     <= '0;
			c     <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy  <= 1'b1;
				phase <= 1'b0;
				r     <= '0;
				c     <= '0;
			end else if (busy) begin
				phase <= !phase;
				if (phase) begin
					c <= (c == last) ? '0 : c + 4'd1;
					if (c == last)
						r <= r + 4'd1;
					if (c == last && r == last) begin
						busy <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/xcorr_engine.sv ====
// 3x3 correlation with zero padding; nine cycles per pixel, taps walked back to back
`default_nettype none

module xcorr_engine
	import tmip_data_pkg::*;
(
	input  wire       clk,
	input  wire       rst_n,
	input  wire       start,
	input  side_t     side,
	input  template_t taps,
	output logic      done,
	mem_if.engine     img,
	mem_if.engine     res,
	output coord_t    max_row,
	output coord_t    max_col
);

	logic   busy;
	logic [3:0] tap;
	coord_t r, c, last;
	logic [1:0] ti, tj;
	logic   in_rng;

	// aligned with rdata
	logic   v1, in1, last1;
	logic [3:0] tap1;
	coord_t row1, col1;
	pixel_t coef1;

	// write stage
	logic   wr, wr_last;
	coord_t wr_row, wr_col;
	corr_t  acc, prod, max_val;

	assign last = coord_t'(side - 5'd1);
	assign ti = (tap < 4'd3) ? 2'd0 : (tap < 4'd6) ? 2'd1 : 2'd2;
	assign tj = 2'(tap - 4'(ti) * 4'd3);
	assign in_rng = !(ti == 2'd0 && r == 4'd0) && !(ti == 2'd2 && r == last)
	             && !(tj == 2'd0 && c == 4'd0) && !(tj == 2'd2 && c == last);

	// out-of-range taps still read somewhere, the product is dropped
	assign img.addr = addr_t'(r) * addr_t'(side) + addr_t'(c) + addr_t'(ti) * addr_t'(side)
	                + addr_t'(tj) - addr_t'(side) - 8'd1;
	assign img.wen   = 1'b0;
	assign img.wdata = '0;

	assign prod = in1 ? corr_t'(img.rdata) * corr_t'(coef1) : '0;

	// idle outputs stay zero, the result port is shared with the reader
	assign res.wen   = wr;
	assign res.addr  = wr ? addr_t'(wr_row) * addr_t'(side) + addr_t'(wr_col) : '0;
	assign res.wdata = wr ? acc : '0;

	//============================================================
	// tap walk
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			tap  <= '0;
			r    <= '0;
			c    <= '0;
		end else if (start) begin
			busy <= 1'b1;
			tap  <= '0;
			r    <= '0;
			c    <= '0;
		end else if (busy) begin
			tap <= (tap == 4'd8) ? 4'd0 : tap + 4'd1;
			if (tap == 4'd8) begin
				c <= (c == last) ? '0 : c + 4'd1;
				if (c == last)
					r <= r + 4'd1;
				if (c == last && r == last)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		coef1 <= taps[tap];
		tap1  <= tap;
		in1   <= in_rng;
		row1  <= r;
		col1  <= c;
		last1 <= r == last && c == last;
		if (v1)
			acc <= (tap1 == 4'd0) ? prod : acc + prod;
		wr_row  <= row1;
		wr_col  <= col1;
		wr_last <= last1;
	end

	//============================================================
	// result write and max
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			v1      <= 1'b0;
			wr      <= 1'b0;
			done    <= 1'b0;
			max_val <= '0;
			max_row <= '0;
			max_col <= '0;
		end else begin
			v1   <= busy;
			wr   <= v1 && tap1 == 4'd8;
			done <= wr && wr_last;
			// strictly greater, so the first hit in raster order stays
			if (wr && ((wr_row == 4'd0 && wr_col == 4'd0) || acc > max_val)) begin
				max_val <= acc;
				max_row <= wr_row;
				max_col <= wr_col;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/result_reader.sv ====
// streams side*side results in raster order; outputs are zero outside the burst
`default_nettype none

module result_reader
	import tmip_data_pkg::*;
(
	input  wire    clk,
	input  wire    rst_n,
	input  wire    start,
	input  side_t  side,
	input  coord_t max_row,
	input  coord_t max_col,
	mem_if.engine  res,
	output logic   done,
	output logic   out_valid,
	output corr_t  out_value,
	output coord_t out_x,
	output coord_t out_y
);

	logic       busy;
	logic       rd_valid;  // res.rdata holds a result
	logic [8:0] cnt;  // up to 256 reads

	assign res.addr  = busy ? cnt[7:0] : '0;
	assign res.wen   = 1'b0;
	assign res.wdata = '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			rd_valid  <= 1'b0;
			cnt       <= '0;
			done      <= 1'b0;
			out_valid <= 1'b0;
			out_value <= '0;
			out_x     <= '0;
			out_y     <= '0;
		end else begin
			if (start) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 9'd1;
				if (cnt == 9'(side) * 9'(side) - 9'd1)
					busy <= 1'b0;
			end
			rd_valid  <= busy;  // rdata of this read lands next cycle
			out_valid <= rd_valid;
			out_value <= rd_valid ? res.rdata : '0;
			out_x     <= rd_valid ? max_row : '0;
			out_y     <= rd_valid ? max_col : '0;
			done      <= out_valid && !rd_valid;
		end
	end

endmodule

`default_nettype wire

// ==== design/tmip_top.sv ====
// template matcher top; one load at a time, no new load until the output burst ends
`default_nettype none

module tmip_top
	import tmip_data_pkg::*;
#(
	parameter int MAX_ACTIONS = 8,
	parameter int IMG_DEPTH   = 256
) (
	input  wire     clk,
	input  wire     rst_n,
	input  wire     in_valid,
	input  wire     in_valid_2,
	input  pixel_t  image,
	input  pixel_t  template,
	input  side_t   img_size,
	input  action_t action,
	output logic    out_valid,
	output corr_t   out_value,
	output coord_t  out_x,
	output coord_t  out_y
);

	side_t     side_in, side;
	template_t taps;
	action_t   actions [MAX_ACTIONS];
	logic      loaded, pool_start, pool_done, adjust_start, adjust_done;
	logic      xcorr_start, xcorr_done, stream_start, stream_done;
	coord_t    max_row, max_col;

	mem_if #(.data_t(pixel_t)) ld_if ();
	mem_if #(.data_t(pixel_t)) pool_if ();
	mem_if #(.data_t(pixel_t)) adj_if ();
	mem_if #(.data_t(pixel_t)) xc_if ();
	mem_if #(.data_t(pixel_t)) img_if ();
	mem_if #(.data_t(corr_t))  xres_if ();
	mem_if #(.data_t(corr_t))  rres_if ();
	mem_if #(.data_t(corr_t))  res_if ();

	// writer and reader never overlap and drive zero when idle
	assign res_if.addr   = xres_if.addr | rres_if.addr;
	assign res_if.wen    = xres_if.wen | rres_if.wen;
	assign res_if.wdata  = xres_if.wdata | rres_if.wdata;
	assign xres_if.rdata = res_if.rdata;
	assign rres_if.rdata = res_if.rdata;

	input_loader #(.MAX_ACTIONS(MAX_ACTIONS)) u_loader (.clk, .rst_n, .in_valid, .in_valid_2,
		.image, .template, .img_size, .action, .mem(ld_if.engine), .side_in, .taps,
		.actions, .loaded);

	op_sequencer #(.MAX_ACTIONS(MAX_ACTIONS)) u_seq (.clk, .rst_n, .loaded, .side_in,
		.actions, .pool_done, .adjust_done, .xcorr_done, .stream_done, .side, .pool_start,
		.adjust_start, .xcorr_start, .stream_start, .loader_mem(ld_if.memory),
		.pool_mem(pool_if.memory), .adjust_mem(adj_if.memory), .xcorr_mem(xc_if.memory),
		.img_mem(img_if.engine));

	pool_engine u_pool (.clk, .rst_n, .start(pool_start), .side, .done(pool_done),
		.mem(pool_if.engine));

	adjust_engine u_adjust (.clk, .rst_n, .start(adjust_start), .side, .done(adjust_done),
		.mem(adj_if.engine));

	xcorr_engine u_xcorr (.clk, .rst_n, .start(xcorr_start), .side, .taps, .done(xcorr_done),
		.img(xc_if.engine), .res(xres_if.engine), .max_row, .max_col);

	result_reader u_reader (.clk, .rst_n, .start(stream_start), .side, .max_row, .max_col,
		.res(rres_if.engine), .done(stream_done), .out_valid, .out_value, .out_x, .out_y);

	sync_ram #(.IMG_DEPTH(IMG_DEPTH), .data_t(pixel_t)) u_img_ram (.clk, .port(img_if.memory));
	sync_ram #(.IMG_DEPTH(IMG_DEPTH), .data_t(corr_t))  u_res_ram (.clk, .port(res_if.memory));

endmodule

`default_nettype wire

// ==== test/tmip_tb.sv ====
// self-checking testbench; needs timing support, stimulus from a fixed seed, one DUT, no waves
`default_nettype none

module tmip_tb
	import tmip_data_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RUNS = 14;
	localparam int RUN_SIDES [N_RUNS] = '{4, 8, 16, 16, 8, 4, 16, 8, 4, 16, 16, 8, 16, 4};

	logic    clk = 1'b0;
	logic    rst_n, in_valid, in_valid_2;
	pixel_t  image, template;
	side_t   img_size;
	action_t action;
	logic    out_valid;
	corr_t   out_value;
	coord_t  out_x, out_y;

	// stimulus and reference model state
	pixel_t  img_in [256];
	pixel_t  tpl [TAPS];
	pixel_t  m_img [256];
	int      m_side;
	corr_t   exp_map [256];
	coord_t  exp_row, exp_col;
	action_t acts [$];
	int      seed;
	int      errors = 0;
	int      checks = 0;
	int      tests = 0;
	int      cycles = 0;
	int      limit;

	tmip_top #(.MAX_ACTIONS(8), .IMG_DEPTH(256)) DUT (
		.clk, .rst_n, .in_valid, .in_valid_2, .image, .template, .img_size, .action,
		.out_valid, .out_value, .out_x, .out_y
	);

	always #10 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("Something failed");
			$finish;
		end
	end

	function automatic int cycle_budget();
		int sum;
		sum = 0;
		for (int i = 0; i < N_RUNS; i++)
			sum += RUN_SIDES[i] * RUN_SIDES[i] * 40 + 200;
		return sum;
	endfunction

	//============================================================
	// reference model
	//============================================================
	function automatic pixel_t larger(input pixel_t a, input pixel_t b);
		return (a > b) ? a : b;
	endfunction

	function automatic pixel_t brighten(input pixel_t p);
		int even;
		even = int'(p) & ~1;  // lowest bit cleared
		return pixel_t'(even / 2 + BRIGHT_OFFSET);
	endfunction

	function automatic void max_pool();
		pixel_t nxt [256];
		int h;
		if (m_side == 4)
			return;  // 4x4 stays as it is
		h = m_side / 2;
		for (int r = 0; r < h; r++)
			for (int c = 0; c < h; c++)
				nxt[r * h + c] = larger(
					larger(m_img[2 * r * m_side + 2 * c], m_img[2 * r * m_side + 2 * c + 1]),
					larger(m_img[(2 * r + 1) * m_side + 2 * c],
						m_img[(2 * r + 1) * m_side + 2 * c + 1]));
		m_img = nxt;
		m_side = h;
	endfunction

	function automatic void crop_brighten();
		pixel_t nxt [256];
		int h;
		int off;
		h = (m_side > 4) ? m_side / 2 : m_side;
		off = (m_side > 4) ? m_side / 4 : 0;  // centre block
		for (int r = 0; r < h; r++)
			for (int c = 0; c < h; c++)
				nxt[r * h + c] = brighten(m_img[(r + off) * m_side + c + off]);
		m_img = nxt;
		m_side = h;
	endfunction

	function automatic void correlate();
		longint acc;
		longint best;
		int rr;
		int cc;
		best = 0;
		for (int r = 0; r < m_side; r++)
			for (int c = 0; c < m_side; c++) begin
				acc = 0;
				for (int i = 0; i < 3; i++)
					for (int j = 0; j < 3; j++) begin
						rr = r + i - 1;
						cc = c + j - 1;
						if (rr >= 0 && rr < m_side && cc >= 0 && cc < m_side)
							acc += longint'(tpl[3 * i + j]) * longint'(m_img[rr * m_side + cc]);
					end
				exp_map[r * m_side + c] = corr_t'(acc);
				if ((r == 0 && c == 0) || acc > best) begin  // first in raster order wins
					best = acc;
					exp_row = coord_t'(r);
					exp_col = coord_t'(c);
				end
			end
	endfunction

	function automatic void build_model(input int sz);
		m_side = sz;
		for (int k = 0; k < 256; k++)
			m_img[k] = img_in[k];
		foreach (acts[i])
			case (acts[i])
				ACT_POOL:   max_pool();
				ACT_ADJUST: crop_brighten();
				default:    correlate();
			endcase
	endfunction

	//============================================================
	// checks and stimulus
	//============================================================
	task automatic check_value(input string what, input corr_t expected, input corr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic check_pos(input string what, input coord_t expected, input coord_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", what, expected, actual);
		end
	endtask

	task automatic make_stimulus(input int sz, input bit twin);
		int half;
		int a;
		int b;
		for (int k = 0; k < sz * sz; k++)
			img_in[k] = twin ? pixel_t'($random(seed) % 900) : pixel_t'($random(seed));
		for (int k = 0; k < TAPS; k++)
			tpl[k] = twin ? ((k == 4) ? 16'sd1 : 16'sd0) : pixel_t'($random(seed));
		if (twin) begin  // identity template, same peak twice
			half = sz * sz / 2;
			a = $random(seed) & (half - 1);
			b = half + ($random(seed) & (half - 1));
			img_in[a] = 16'sd1000;
			img_in[b] = 16'sd1000;
		end
	endtask

	task automatic load_inputs(input int sz);
		@(posedge clk);
		#2;
		for (int k = 0; k < sz * sz; k++) begin
			in_valid = 1'b1;
			image    = img_in[k];
			template = (k < TAPS) ? tpl[k] : '0;
			img_size = (k == 0) ? side_t'(sz) : '0;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
		image    = '0;
		template = '0;
		img_size = '0;
		@(posedge clk);  // idle gap before the queue
		#2;
		foreach (acts[i]) begin
			in_valid_2 = 1'b1;
			action     = acts[i];
			@(posedge clk);
			#2;
		end
		in_valid_2 = 1'b0;
		action     = ACT_XCORR;
	endtask

	task automatic run_case(input string name, input int sz, input bit twin);
		int beats;
		int errs_before;
		errs_before = errors;
		beats = 0;
		repeat (2) @(posedge clk);
		make_stimulus(sz, twin);
		build_model(sz);
		load_inputs(sz);
		@(negedge clk);
		while (!out_valid)
			@(negedge clk);
		while (out_valid) begin
			if (beats < m_side * m_side)
				check_value($sformatf("%s beat %0d", name, beats), exp_map[beats], out_value);
			check_pos($sformatf("%s max row", name), exp_row, out_x);
			check_pos($sformatf("%s max col", name), exp_col, out_y);
			beats++;
			@(negedge clk);
		end
		if (beats != m_side * m_side) begin
			errors++;
			$display("%s: the burst had %0d beats instead of %0d", name, beats, m_side * m_side);
		end
		tests++;
		$display("%s: side %0d to %0d, %0d beats, %s", name, sz, m_side, beats,
			(errors == errs_before) ? "pass" : "FAIL");
	endtask

	//============================================================
	// test sequence
	//============================================================
	initial begin
		seed       = 32'h30b4057c;
		limit      = cycle_budget();
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_valid_2 = 1'b0;
		image      = '0;
		template   = '0;
		img_size   = '0;
		action     = ACT_XCORR;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			errors++;
			$display("out_valid is not low after reset");
		end
		check_value("reset out_value", '0, out_value);
		check_pos("reset out_x", '0, out_x);
		check_pos("reset out_y", '0, out_y);

		acts = '{ACT_XCORR};
		run_case("xcorr_4", 4, 1'b0);
		run_case("xcorr_8", 8, 1'b0);
		run_case("xcorr_16", 16, 1'b0);

		acts = '{ACT_POOL, ACT_XCORR};
		run_case("pool_16", 16, 1'b0);
		run_case("pool_8", 8, 1'b0);
		run_case("pool_4_noop", 4, 1'b0);

		acts = '{ACT_ADJUST, ACT_XCORR};  // full range pixels, negative and odd
		run_case("adjust_16", 16, 1'b0);
		run_case("adjust_8", 8, 1'b0);
		run_case("adjust_4", 4, 1'b0);

		acts = '{ACT_POOL, ACT_ADJUST, ACT_POOL, ACT_XCORR};
		run_case("mixed_4", 16, 1'b0);
		acts = '{ACT_POOL, ACT_ADJUST, ACT_POOL, ACT_ADJUST, ACT_POOL, ACT_ADJUST,
			ACT_ADJUST, ACT_XCORR};
		run_case("mixed_8", 16, 1'b0);

		acts = '{ACT_XCORR};
		run_case("twin_max", 8, 1'b1);

		// second load right after a finished burst
		run_case("reload_16", 16, 1'b0);
		run_case("reload_4", 4, 1'b0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
design/tmip_data_pkg.sv
design/tmip_ctrl_pkg.sv
design/mem_if.sv
design/sync_ram.sv
design/input_loader.sv
design/op_sequencer.sv
design/pool_engine.sv
design/adjust_engine.sv
design/xcorr_engine.sv
design/result_reader.sv
design/tmip_top.sv
test/tmip_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tmip_tb
RTL_TOP   ?= tmip_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
JOBS      ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
